// File: source/butterfly_unit.sv
interface pair_if #(
    parameter int N = 16
);
    logic                   issue;
    logic [$clog2(N)-2:0]   tw_idx;
    logic [$clog2(N)-1:0]   dst_lo;
    logic [$clog2(N)-1:0]   dst_hi;

    modport ctrl (output issue, tw_idx, dst_lo, dst_hi);
    modport bfly (input  issue, tw_idx, dst_lo, dst_hi);
endinterface

module butterfly_unit
    import fft_types_pkg::*;
    import fft_cfg_pkg::*;
#(
    parameter int N = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    pair_if.bfly                 pair,
    input  cplx_in_t             a_i,
    input  cplx_in_t             b_i,
    output logic                 wr_en_o,
    output logic [$clog2(N)-1:0] wr_lo_addr_o,
    output logic [$clog2(N)-1:0] wr_hi_addr_o,
    output cplx_out_t            sum_o,
    output cplx_out_t            diff_o
);

    localparam int AW        = $clog2(N);
    localparam int TW_STRIDE = TW_MAX_N / N;
    localparam int PROD_W    = DATA_W + TW_W + 2;
    localparam logic signed [PROD_W-1:0] RND_HALF = 1 <<< (TW_FRAC - 1);

    // control lined up with the buffer read
    logic                   issue_d;
    logic [AW-2:0]          tw_d;
    logic [AW-1:0]          lo_d, hi_d;

    // stage 1
    logic                   v1;
    logic [AW-1:0]          lo1, hi1;
    cplx_out_t              sum1;
    logic signed [DATA_W:0] dre1, dim1;
    tw_t                    tw1;

    // stage 2 arithmetic
    logic signed [PROD_W-1:0] prod_re, prod_im;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_d <= 1'b0;
            v1      <= 1'b0;
            wr_en_o <= 1'b0;
        end else begin
            issue_d <= pair.issue;
            v1      <= issue_d;
            wr_en_o <= v1;
        end
    end

    // ------------------------------------------------------------------
    // stage 1: sum, difference and twiddle fetch
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        tw_d    <= pair.tw_idx;
        lo_d    <= pair.dst_lo;
        hi_d    <= pair.dst_hi;

        lo1     <= lo_d;
        hi1     <= hi_d;
        sum1.re <= OUT_W'(a_i.re) + OUT_W'(b_i.re);
        sum1.im <= OUT_W'(a_i.im) + OUT_W'(b_i.im);
        dre1    <= (DATA_W + 1)'(a_i.re) - (DATA_W + 1)'(b_i.re);
        dim1    <= (DATA_W + 1)'(a_i.im) - (DATA_W + 1)'(b_i.im);
        // smaller frames skip through the 64 point table
        tw1     <= twiddle_table[int'(tw_d) * TW_STRIDE];
    end

    // (dre + i*dim) * (c - i*s), rounded half up before the shift
    assign prod_re = dre1 * tw1.c + dim1 * tw1.s + RND_HALF;
    assign prod_im = dim1 * tw1.c - dre1 * tw1.s + RND_HALF;

    // ------------------------------------------------------------------
    // stage 2: rotate the difference
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        wr_lo_addr_o <= lo1;
        wr_hi_addr_o <= hi1;
        sum_o        <= sum1;
        diff_o.re    <= OUT_W'(prod_re >>> TW_FRAC);
        diff_o.im    <= OUT_W'(prod_im >>> TW_FRAC);
    end

endmodule

// File: source/fft_cfg_pkg.sv
package fft_cfg_pkg;

    // twiddle format Q1.14
    parameter int TW_W = 16;
    parameter int TW_FRAC = 14;

    // table is built for the largest frame, smaller N steps through it
    parameter int TW_MAX_N = 64;

    // butterfly register stages after the buffer read
    parameter int BFLY_LAT = 2;

    // cos and sin of 2*pi*k/TW_MAX_N, W^k = c - i*s
    typedef struct packed {
        logic signed [TW_W-1:0] c;
        logic signed [TW_W-1:0] s;
    } tw_t;

    // ------------------------------------------------------------------
    // first half circle, k = 0 .. TW_MAX_N/2-1
    // ------------------------------------------------------------------
    parameter tw_t twiddle_table [TW_MAX_N/2] = '{
        '{ 16384,     0}, '{ 16305,  1606}, '{ 16069,  3196}, '{ 15679,  4756},
        '{ 15137,  6270}, '{ 14449,  7723}, '{ 13623,  9102}, '{ 12665, 10394},
        '{ 11585, 11585}, '{ 10394, 12665}, '{  9102, 13623}, '{  7723, 14449},
        '{  6270, 15137}, '{  4756, 15679}, '{  3196, 16069}, '{  1606, 16305},
        '{     0, 16384}, '{ -1606, 16305}, '{ -3196, 16069}, '{ -4756, 15679},
        '{ -6270, 15137}, '{ -7723, 14449}, '{ -9102, 13623}, '{-10394, 12665},
        '{-11585, 11585}, '{-12665, 10394}, '{-13623,  9102}, '{-14449,  7723},
        '{-15137,  6270}, '{-15679,  4756}, '{-16069,  3196}, '{-16305,  1606}
    };

endpackage

// File: source/fft_stage_top.sv
module fft_stage_top
    import fft_types_pkg::*;
#(
    parameter int N = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 frame_start_i,
    input  logic                 frame_release_i,
    input  logic                 in_valid_i,
    input  cplx_in_t             in_sample_i,
    input  logic [$clog2(N)-1:0] out_rd_addr_i,
    output cplx_out_t            out_rd_data_o,
    output logic                 busy_o,
    output logic                 done_o
);

    localparam int AW = $clog2(N);

    logic          in_wr_en;
    logic [AW-1:0] in_wr_addr;
    logic [AW-1:0] rd_addr_lo;
    logic [AW-1:0] rd_addr_hi;
    cplx_in_t      bfly_a;
    cplx_in_t      bfly_b;
    logic          out_wr_en;
    logic [AW-1:0] out_lo_addr;
    logic [AW-1:0] out_hi_addr;
    cplx_out_t     out_sum;
    cplx_out_t     out_diff;

    pair_if #(.N(N)) pair_bus ();

    stage_control #(.N(N)) u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .frame_start_i   (frame_start_i),
        .frame_release_i (frame_release_i),
        .in_valid_i      (in_valid_i),
        .in_wr_en_o      (in_wr_en),
        .in_wr_addr_o    (in_wr_addr),
        .rd_addr_lo_o    (rd_addr_lo),
        .rd_addr_hi_o    (rd_addr_hi),
        .pair            (pair_bus.ctrl),
        .busy_o          (busy_o),
        .done_o          (done_o)
    );

    // input frame, only port a writes
    sample_ram #(.payload_t(cplx_in_t), .N(N)) u_in_ram (
        .clk         (clk),
        .wr_en_a_i   (in_wr_en),
        .wr_addr_a_i (in_wr_addr),
        .wr_data_a_i (in_sample_i),
        .wr_en_b_i   (1'b0),
        .wr_addr_b_i ('0),
        .wr_data_b_i ('0),
        .rd_addr_a_i (rd_addr_lo),
        .rd_data_a_o (bfly_a),
        .rd_addr_b_i (rd_addr_hi),
        .rd_data_b_o (bfly_b)
    );

    butterfly_unit #(.N(N)) u_bfly (
        .clk          (clk),
        .rst_n        (rst_n),
        .pair         (pair_bus.bfly),
        .a_i          (bfly_a),
        .b_i          (bfly_b),
        .wr_en_o      (out_wr_en),
        .wr_lo_addr_o (out_lo_addr),
        .wr_hi_addr_o (out_hi_addr),
        .sum_o        (out_sum),
        .diff_o       (out_diff)
    );

    // result frame, sum to j and rotated difference to j+N/2
    sample_ram #(.payload_t(cplx_out_t), .N(N)) u_out_ram (
        .clk         (clk),
        .wr_en_a_i   (out_wr_en),
        .wr_addr_a_i (out_lo_addr),
        .wr_data_a_i (out_sum),
        .wr_en_b_i   (out_wr_en),
        .wr_addr_b_i (out_hi_addr),
        .wr_data_b_i (out_diff),
        .rd_addr_a_i (out_rd_addr_i),
        .rd_data_a_o (out_rd_data_o),
        .rd_addr_b_i ('0),
        .rd_data_b_o ()
    );

endmodule

// File: source/fft_types_pkg.sv
package fft_types_pkg;

    // ------------------------------------------------------------------
    // sample widths
    // ------------------------------------------------------------------

    // width of one input component
    parameter int DATA_W = 16;

    // two extra bits hold the growth of a+b and of the rotated a-b
    parameter int OUT_W = DATA_W + 2;

    // ------------------------------------------------------------------
    // complex sample types
    // ------------------------------------------------------------------

    // input frame sample, re in the upper half
    typedef struct packed {
        logic signed [DATA_W-1:0] re;
        logic signed [DATA_W-1:0] im;
    } cplx_in_t;

    // butterfly result as stored in the output buffer
    typedef struct packed {
        logic signed [OUT_W-1:0] re;
        logic signed [OUT_W-1:0] im;
    } cplx_out_t;

endpackage

// File: source/sample_ram.sv
module sample_ram #(
    parameter type payload_t = logic [31:0],
    parameter int  N         = 16
) (
    input  logic                 clk,

    // write port a
    input  logic                 wr_en_a_i,
    input  logic [$clog2(N)-1:0] wr_addr_a_i,
    input  payload_t             wr_data_a_i,

    // write port b
    input  logic                 wr_en_b_i,
    input  logic [$clog2(N)-1:0] wr_addr_b_i,
    input  payload_t             wr_data_b_i,

    // registered read ports
    input  logic [$clog2(N)-1:0] rd_addr_a_i,
    output payload_t             rd_data_a_o,
    input  logic [$clog2(N)-1:0] rd_addr_b_i,
    output payload_t             rd_data_b_o
);

    payload_t mem [N];

    // both write ports may fire in one cycle on different addresses
    always_ff @(posedge clk) begin
        if (wr_en_a_i) begin
            mem[wr_addr_a_i] <= wr_data_a_i;
        end
        if (wr_en_b_i) begin
            mem[wr_addr_b_i] <= wr_data_b_i;
        end
    end

    // read data shows up one cycle after the address
    always_ff @(posedge clk) begin
        rd_data_a_o <= mem[rd_addr_a_i];
        rd_data_b_o <= mem[rd_addr_b_i];
    end

endmodule

// File: source/stage_control.sv
module stage_control
    import fft_cfg_pkg::*;
#(
    parameter int N = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,

    // frame handshake levels from outside
    input  logic                 frame_start_i,
    input  logic                 frame_release_i,
    input  logic                 in_valid_i,

    // input buffer write side
    output logic                 in_wr_en_o,
    output logic [$clog2(N)-1:0] in_wr_addr_o,

    // input buffer read side
    output logic [$clog2(N)-1:0] rd_addr_lo_o,
    output logic [$clog2(N)-1:0] rd_addr_hi_o,

    pair_if.ctrl                 pair,

    output logic                 busy_o,
    output logic                 done_o
);

    localparam int AW      = $clog2(N);
    localparam int JW      = AW - 1;
    localparam int DRAIN_W = $clog2(BFLY_LAT + 1);

    typedef enum logic [1:0] {
        L_IDLE,
        L_LOAD,
        L_WAIT
    } load_state_t;

    typedef enum logic [1:0] {
        C_IDLE,
        C_ISSUE,
        C_DRAIN
    } cmp_state_t;

    load_state_t        load_state;
    cmp_state_t         cmp_state;
    logic [AW-1:0]      wr_addr_q;
    logic [JW-1:0]      j_q;
    logic               issue_q;
    logic [DRAIN_W-1:0] drain_cnt_q;
    logic               done_q;
    logic               busy_q;
    logic               load_last;
    logic               last_pair;
    logic               drain_last;

    // ------------------------------------------------------------------
    // load side
    // ------------------------------------------------------------------

    // samples go straight to the buffer, only the address is kept here
    assign in_wr_en_o   = (load_state == L_LOAD) && in_valid_i;
    assign in_wr_addr_o = wr_addr_q;

    // Nth sample accepted this cycle
    assign load_last = in_wr_en_o && (wr_addr_q == AW'(N - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_state <= L_IDLE;
            wr_addr_q  <= '0;
        end else begin
            case (load_state)
                L_IDLE: begin
                    wr_addr_q <= '0;
                    if (frame_start_i) begin
                        load_state <= L_LOAD;
                    end
                end
                L_LOAD: begin
                    if (in_valid_i) begin
                        wr_addr_q <= wr_addr_q + 1'b1;
                        if (load_last) begin
                            load_state <= L_WAIT;
                        end
                    end
                end
                L_WAIT: begin
                    // hold the frame until the result has been taken
                    if (frame_release_i && cmp_state == C_IDLE) begin
                        load_state <= L_IDLE;
                    end
                end
                default: begin
                    load_state <= L_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // compute side
    // ------------------------------------------------------------------

    assign last_pair  = (j_q == JW'(N / 2 - 1));
    assign drain_last = (cmp_state == C_DRAIN) && (drain_cnt_q == DRAIN_W'(BFLY_LAT));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmp_state   <= C_IDLE;
            j_q         <= '0;
            issue_q     <= 1'b0;
            drain_cnt_q <= '0;
            done_q      <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (cmp_state)
                C_IDLE: begin
                    // first pair goes out the cycle after the last write
                    if (load_last) begin
                        cmp_state <= C_ISSUE;
                        j_q       <= '0;
                        issue_q   <= 1'b1;
                    end
                end
                C_ISSUE: begin
                    if (last_pair) begin
                        cmp_state   <= C_DRAIN;
                        issue_q     <= 1'b0;
                        drain_cnt_q <= '0;
                    end else begin
                        j_q <= j_q + 1'b1;
                    end
                end
                C_DRAIN: begin
                    // wait out the buffer read and the butterfly pipe
                    if (drain_last) begin
                        cmp_state <= C_IDLE;
                        done_q    <= 1'b1;
                    end else begin
                        drain_cnt_q <= drain_cnt_q + 1'b1;
                    end
                end
                default: begin
                    cmp_state <= C_IDLE;
                    issue_q   <= 1'b0;
                end
            endcase
        end
    end

    // busy spans first accepted sample up to done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
        end else if (drain_last) begin
            busy_q <= 1'b0;
        end else if (in_wr_en_o) begin
            busy_q <= 1'b1;
        end
    end

    // pair j and j+N/2 differ only in the top address bit
    assign rd_addr_lo_o = {1'b0, j_q};
    assign rd_addr_hi_o = {1'b1, j_q};

    assign pair.issue  = issue_q;
    assign pair.tw_idx = j_q;
    assign pair.dst_lo = {1'b0, j_q};
    assign pair.dst_hi = {1'b1, j_q};

    assign busy_o = busy_q;
    assign done_o = done_q;

endmodule

// File: tb.f
source/fft_types_pkg.sv
source/fft_cfg_pkg.sv
source/sample_ram.sv
source/butterfly_unit.sv
source/stage_control.sv
source/fft_stage_top.sv
test/fft_stage_props.sv
test/fft_stage_tb.sv

// File: test/fft_stage_props.sv
module fft_stage_props
    import fft_cfg_pkg::*;
#(
    parameter int N = 16
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 issue_i,
    input logic                 in_wr_en_i,
    input logic [$clog2(N)-1:0] in_wr_addr_i,
    input logic                 busy_i,
    input logic                 done_i
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int AW = $clog2(N);

    logic load_done_q;
    int   fail_count = 0;

    // set by the Nth sample write and cleared by done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_done_q <= 1'b0;
        end else if (done_i) begin
            load_done_q <= 1'b0;
        end else if (in_wr_en_i && in_wr_addr_i == AW'(N - 1)) begin
            load_done_q <= 1'b1;
        end
    end

    a_issue_run: assert property (@(posedge clk) disable iff (!rst_n)
        issue_i [*(N / 2)] |=> !issue_i)
        else begin
            $error("issue held for more than N/2 cycles");
            fail_count++;
        end

    a_done_width: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |=> !done_i)
        else begin
            $error("done_o wider than one cycle");
            fail_count++;
        end

    // last pair plus buffer read, butterfly pipe and one more cycle
    a_done_delay: assert property (@(posedge clk) disable iff (!rst_n)
        issue_i ##1 !issue_i |-> ##(BFLY_LAT + 1) done_i)
        else begin
            $error("done_o not BFLY_LAT+2 cycles after last issue");
            fail_count++;
        end

    a_no_late_write: assert property (@(posedge clk) disable iff (!rst_n)
        busy_i && load_done_q |-> !in_wr_en_i)
        else begin
            $error("input buffer written after the frame was complete");
            fail_count++;
        end

endmodule

bind stage_control fft_stage_props #(.N(N)) u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue_i      (issue_q),
    .in_wr_en_i   (in_wr_en_o),
    .in_wr_addr_i (in_wr_addr_o),
    .busy_i       (busy_o),
    .done_i       (done_o)
);

// File: test/fft_stage_tb.sv
module fft_stage_tb
    import fft_types_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N           = 16;
    localparam int AW          = $clog2(N);
    localparam int NFRAMES     = 2;
    localparam int TIMEOUT_CYC = NFRAMES * (N * 8 + N / 2 + 20) + 100;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          frame_start_i;
    logic          frame_release_i;
    logic          in_valid_i;
    cplx_in_t      in_sample_i;
    logic [AW-1:0] out_rd_addr_i;
    cplx_out_t     out_rd_data_o;
    logic          busy_o;
    logic          done_o;

    // frame f of the trace starts at index f*N in both arrays
    cplx_in_t      in_mem  [NFRAMES * N];
    cplx_out_t     exp_mem [NFRAMES * N];

    int            cyc = 0;
    int            errors = 0;
    int            test_base = 0;
    int            n_tests = 0;
    int            last_cyc;
    int            done_cyc;

    fft_stage_top #(.N(N)) uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .frame_start_i   (frame_start_i),
        .frame_release_i (frame_release_i),
        .in_valid_i      (in_valid_i),
        .in_sample_i     (in_sample_i),
        .out_rd_addr_i   (out_rd_addr_i),
        .out_rd_data_o   (out_rd_data_o),
        .busy_o          (busy_o),
        .done_o          (done_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------

    task automatic compare_value(input string name, input logic [35:0] exp_v,
                                 input logic [35:0] got_v);
        if (exp_v !== got_v) begin
            $display("mismatch %s exp=%h got=%h", name, exp_v, got_v);
            errors++;
        end
    endtask

    task automatic end_test(input int num, input string name);
        n_tests++;
        if (errors == test_base) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - test_base);
        end
        test_base = errors;
    endtask

    task automatic read_trace(output bit ok);
        int          fd;
        int          n;
        int          n_in;
        int          n_out;
        string       line;
        byte         tag;
        logic [17:0] v_re;
        logic [17:0] v_im;
        n_in  = 0;
        n_out = 0;
        ok    = 1'b0;
        fd    = $fopen("test/fft_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open trace file test/fft_trace.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h", tag, v_re, v_im);
                if (n != 3) begin
                    $display("trace line not understood: %s", line);
                    errors++;
                end else if (tag == "i" && n_in < NFRAMES * N) begin
                    in_mem[n_in] = {v_re[15:0], v_im[15:0]};
                    n_in++;
                end else if (tag == "o" && n_out < NFRAMES * N) begin
                    exp_mem[n_out] = {v_re, v_im};
                    n_out++;
                end else begin
                    $display("unexpected trace entry: %s", line);
                    errors++;
                end
            end
        end
        $fclose(fd);
        if (n_in != NFRAMES * N || n_out != NFRAMES * N) begin
            $display("trace holds %0d inputs and %0d outputs but %0d of each are needed",
                     n_in, n_out, NFRAMES * N);
            errors++;
        end else begin
            ok = 1'b1;
        end
    endtask

    // one start pulse arms the load for N strobes with random idle gaps
    task automatic load_frame(input int f);
        int gap;
        @(posedge clk);
        frame_start_i <= 1'b1;
        @(posedge clk);
        frame_start_i <= 1'b0;
        for (int k = 0; k < N; k++) begin
            gap = $urandom % 4;
            repeat (gap) begin
                @(posedge clk);
                in_valid_i <= 1'b0;
            end
            @(posedge clk);
            in_valid_i  <= 1'b1;
            in_sample_i <= in_mem[f * N + k];
        end
        // cycle in which the last sample is taken
        @(negedge clk);
        last_cyc = cyc;
        @(posedge clk);
        in_valid_i <= 1'b0;
    endtask

    // strobes with junk data that the loaded frame must ignore
    task automatic send_extra_strobes(input int count);
        for (int k = 0; k < count; k++) begin
            @(posedge clk);
            in_valid_i    <= 1'b1;
            frame_start_i <= 1'b1;
            in_sample_i   <= {16'h5a5a ^ 16'(k), 16'ha5a5};
        end
        @(posedge clk);
        in_valid_i    <= 1'b0;
        frame_start_i <= 1'b0;
    endtask

    // busy must still be up while the pairs are being computed
    task automatic wait_done(output int at_cyc);
        @(negedge clk);
        compare_value("busy_o", 1, busy_o);
        while (!done_o) begin
            @(negedge clk);
        end
        at_cyc = cyc;
    endtask

    task automatic release_frame();
        @(posedge clk);
        frame_release_i <= 1'b1;
        @(posedge clk);
        frame_release_i <= 1'b0;
    endtask

    // read data comes one cycle after the address
    task automatic check_frame(input int f);
        string name;
        for (int k = 0; k < N; k++) begin
            @(posedge clk);
            out_rd_addr_i <= AW'(k);
            @(negedge clk);
            @(negedge clk);
            name = $sformatf("out_rd_data_o[%0d]", k);
            compare_value(name, exp_mem[f * N + k], out_rd_data_o);
        end
    endtask

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------

    initial begin : watchdog
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("timeout waiting for done_o");
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        bit trace_ok;
        rst_n           = 1'b0;
        frame_start_i   = 1'b0;
        frame_release_i = 1'b0;
        in_valid_i      = 1'b0;
        in_sample_i     = '0;
        out_rd_addr_i   = '0;
        void'($urandom(50876));
        read_trace(trace_ok);
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        if (trace_ok) begin
            @(negedge clk);
            compare_value("busy_o", 0, busy_o);
            compare_value("done_o", 0, done_o);
            end_test(1, "reset state");

            load_frame(0);
            fork
                send_extra_strobes(6);
                wait_done(done_cyc);
            join
            check_frame(0);
            end_test(2, "frame 1 results");

            compare_value("done_o latency", N / 2 + 4, done_cyc - last_cyc);
            end_test(3, "done_o latency");

            // enough strobes to fill a whole frame if they were taken
            send_extra_strobes(N);
            @(negedge clk);
            compare_value("busy_o", 0, busy_o);
            check_frame(0);
            end_test(4, "strobes before release");

            release_frame();
            load_frame(1);
            wait_done(done_cyc);
            check_frame(1);
            end_test(5, "frame 2 full scale");
        end

        if (uut.u_ctrl.u_props.fail_count != 0) begin
            $display("controller assertions failed %0d times",
                     uut.u_ctrl.u_props.fail_count);
            errors += uut.u_ctrl.u_props.fail_count;
        end

        $display("%0d tests run, %0d errors", n_tests, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: test/fft_trace.txt
# i <re> <im>: input sample in address order, 16 bit two's complement hex
# o <re> <im>: output buffer word in address order, 18 bit hex, sums then twiddled diffs
i 1064 e0c8
i 1ed4 15dc
i e388 1c18
i 3830 e448
i f2bc 2d44
i 1b50 2960
i ebb8 fbb8
i 0fce d03c
i 0064 00c8
i fed4 05dc
i 1388 fc18
i f830 f448
i 02bc fd44
i fb50 0960
i 0bb8 0bb8
i ffce 003c
o 010c8 3e190
o 01da8 01bb8
o 3f710 01830
o 03060 3d890
o 3f578 02a88
o 016a0 032c0
o 3f770 00770
o 00f9c 3d078
o 01000 3e000
o 023b0 00289
o 3f4b0 03891
o 009b6 3bec0
o 03000 01000
o 01152 3d631
o 00b50 021f1
o 3ded9 02639
i 7fff 8000
i 8000 8000
i 8000 7000
i 8000 8000
i 8000 8000
i 8000 8000
i 7000 8000
i 8000 3000
i 8000 7fff
i 7000 0000
i 7000 8000
i 0000 0000
i 8000 7fff
i 8000 8000
i 8000 7000
i f000 b000
o 3ffff 3ffff
o 3f000 38000
o 3f000 3f000
o 38000 38000
o 30000 3ffff
o 30000 30000
o 3f000 3f000
o 37000 3e000
o 0ffff 30001
o 2f148 3e597
o 00000 15368
o 358c2 04546
o 30001 00000
o 00000 00000
o 2ac99 00000
o 09876 3b49b
